/* sources.f */
logic/l2d_ecc_pkg.sv
logic/l2d_ecc_check.sv
logic/l2d_ecc_err_ctl.sv
logic/l2d_read_select.sv
logic/l2d_ecc_top.sv
testbench/l2d_ecc_assertions.sv
testbench/l2d_ecc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the l2 data ecc testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module l2d_ecc_tb
./obj_dir/Vl2d_ecc_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
   exit 1
fi
exit 0

/* testbench/l2d_ecc_golden.txt */
# kind word cw3 cw2 cw1 cw0 dram_corr dram_uncorr ceen nceen
# exp_data err_corr err_uncorr scrub_corr scrub_uncorr ret_err
0 0 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0000000001 0 0 0 0 0
0 1 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0000000002 0 0 0 0 0
0 2 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0000000003 0 0 0 0 0
0 3 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0080000000 0 0 0 0 0
1 2 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0000000003 0 0 0 0 0
2 1 208000000a 000000001e 4000000019 4000000007 0 0 1 1 0000000002 0 0 0 0 0
3 3 208000000a 000000001e 4000000019 4000000007 0 0 1 1 208000000a 0 0 0 0 0
3 0 208000000a 000000001e 4000000019 4000000007 0 0 1 1 4000000007 0 0 0 0 0
0 0 208000000a 000000001e 4000000019 4000000003 0 0 1 1 0000000001 1 0 0 0 1
1 0 208000000a 000000001e 4000000019 4000000003 0 0 1 1 0000000001 1 0 0 0 1
0 1 208000000a 000000001e 4000000018 4000000007 0 0 1 1 0000000002 1 0 0 0 1
0 2 208000000a 400000001e 4000000019 4000000007 0 0 1 1 0000000003 1 0 0 0 1
3 0 208000000a 000000001e 4000000019 4000000003 0 0 1 1 4000000003 1 0 0 0 0
0 3 208000000a 000000001e 4000000019 4000000003 0 0 1 1 0080000000 1 0 0 0 1
0 0 208000000a 000000001e 4000000019 4000000013 0 0 1 1 0000000002 0 1 0 0 2
1 0 208000000a 000000001e 4000000019 4000000013 0 0 1 1 0000000002 0 1 0 0 2
0 0 208000000a 000000001e 4000000019 4000000003 0 0 0 0 0000000001 1 0 0 0 0
0 0 208000000a 000000001e 4000000019 4000000013 0 0 0 0 0000000002 0 1 0 0 0
3 0 208000000a 000000001e 4000000019 4000000013 0 0 0 0 4000000013 0 1 0 0 0
1 1 208000000a 000000001e 4000000019 4000000007 1 0 0 0 0000000002 1 0 0 0 0
1 1 208000000a 000000001e 4000000019 4000000007 1 0 1 1 0000000002 1 0 0 0 1
1 1 208000000a 000000001e 4000000019 4000000007 0 1 1 1 0000000002 0 1 0 0 2
0 1 208000000a 000000001e 4000000019 4000000007 1 1 1 1 0000000002 0 0 0 0 0
2 2 208000000a 400000001e 4000000019 4000000007 0 0 1 1 0000000003 0 0 1 0 0
2 3 208000000a 400000001e 4000000019 4000000007 0 0 1 1 0080000000 0 0 1 0 0
2 0 208000000a 400000001e 4000000019 4000000007 0 0 1 1 0000000001 0 0 0 0 0
2 0 208000000a 000000001e 4000000019 4000000003 0 0 1 1 0000000001 0 0 1 0 0
2 2 208000000a 000000001e 4000000019 4000000013 0 0 1 1 0000000003 0 0 0 0 0
2 1 208000000a 000000001e 4000000019 4000000013 0 0 1 1 0000000002 0 0 0 1 0
2 3 2080000000 000000001e 4000000019 4000000007 0 0 1 1 0080000000 0 0 0 1 0

/* testbench/l2d_ecc_tb.sv */
////////////////////////////////////////
// testbench for the l2 data ecc check
// golden vectors, random back-pressure
////////////////////////////////////////

module l2d_ecc_tb;
   import l2d_ecc_pkg::*;

   logic rclk = 1'b0;
   logic arst_n, ceen, nceen, in_valid, in_ready, in_dram_corr, in_dram_uncorr;
   logic out_valid, err_corr, err_uncorr, scrub_corr, scrub_uncorr;
   logic out_ready = 1'b0;
   req_kind_e in_kind, out_kind;
   logic [1:0] in_word;
   logic [line_w-1:0] in_line;
   logic [code_w-1:0] out_data;
   logic [ret_err_w-1:0] ret_err;

   // vector store with one entry per golden line
   logic [1:0] v_kind [64], v_word [64], v_ret [64];
   logic [line_w-1:0] v_line [64];
   logic [code_w-1:0] v_data [64];
   logic [7:0] v_flags [64];
   int n_vec = 0, errors = 0, checks = 0, cycles = 0, limit = 0, seed = 27325;
   int exp_q [$];

   always #50 rclk = ~rclk;

   l2d_ecc_top uut (.*);

   task automatic check_value(input string name, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
      checks++;
      if (exp_v !== act_v) begin
         errors++;
         $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
      end
   endtask

   // sink is ready roughly 70 percent of the time
   always @(negedge rclk) begin
      out_ready <= (($random(seed) & 32'h7fffffff) % 10) < 7;
   end

   // compare each output handshake against the oldest accepted vector
   always @(posedge rclk) begin
      int i;
      if (arst_n && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("output handshake with no request outstanding");
         end else begin
            i = exp_q.pop_front();
            check_value($sformatf("vec %0d out_data", i), 64'(v_data[i]), 64'(out_data));
            check_value($sformatf("vec %0d out_kind", i), 64'(v_kind[i]), 64'(out_kind));
            check_value($sformatf("vec %0d flags", i), 64'(v_flags[i]),
                        64'({err_corr, err_uncorr, scrub_corr, scrub_uncorr}));
            check_value($sformatf("vec %0d ret_err", i), 64'(v_ret[i]), 64'(ret_err));
         end
      end
   end

   always @(posedge rclk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout, %0d requests never came out", exp_q.size());
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      int fd, k, dc, du, ce, nce, ec, eu, sc, su, rt;
      logic [code_w-1:0] c3, c2, c1, c0, d;
      string s;
      {arst_n, ceen, nceen, in_valid, in_dram_corr, in_dram_uncorr} = '0;
      in_kind = kind_spc;
      in_word = '0;
      in_line = '0;
      fd = $fopen("testbench/l2d_ecc_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open the golden vector file");
         $display("Something failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            k = $fgets(s, fd);
            if (k > 0 && s[0] != "#" &&
                $sscanf(s, "%d %d %h %h %h %h %d %d %d %d %h %d %d %d %d %d",
                  v_kind[n_vec], v_word[n_vec], c3, c2, c1, c0, dc, du, ce, nce,
                  d, ec, eu, sc, su, rt) == 16) begin
               // dram flags and enables ride in spare bits of v_flags
               v_line[n_vec] = {c3, c2, c1, c0};
               v_data[n_vec] = d;
               v_flags[n_vec] = {dc[0], du[0], ce[0], nce[0], ec[0], eu[0], sc[0], su[0]};
               v_ret[n_vec] = rt[1:0];
               n_vec++;
            end
         end
         $fclose(fd);
         limit = n_vec * 12 + 50;
         repeat (2) @(negedge rclk);
         arst_n = 1'b1;
         for (int i = 0; i < n_vec; i++) begin
            @(negedge rclk);
            if (v_flags[i][5:4] != {ceen, nceen}) begin
               // enables only change with the pipeline empty
               in_valid = 1'b0;
               while (exp_q.size() != 0 || out_valid) @(negedge rclk);
               {ceen, nceen} = v_flags[i][5:4];
               repeat (2) @(negedge rclk);
            end
            in_valid = 1'b1;
            in_kind = req_kind_e'(v_kind[i]);
            in_word = v_word[i];
            in_line = v_line[i];
            {in_dram_corr, in_dram_uncorr} = v_flags[i][7:6];
            #1;
            while (!in_ready) begin
               @(negedge rclk);
               #1;
            end
            exp_q.push_back(i);
            v_flags[i] = {4'b0, v_flags[i][3:0]};
         end
         @(negedge rclk);
         in_valid = 1'b0;
         while (exp_q.size() != 0) @(negedge rclk);
         repeat (3) @(negedge rclk);
         $display("vectors %0d, checks %0d, errors %0d", n_vec, checks, errors);
         if (errors == 0 && n_vec > 0) begin
            $display("Everything OK");
         end else begin
            $display("Something failed");
         end
         $finish;
      end
   end

endmodule

/* testbench/l2d_ecc_assertions.sv */
////////////////////////////////////////
// concurrent checks on the output side
// handshake hold, idle flags, ret_err
////////////////////////////////////////

module l2d_ecc_assertions (
   input logic                                rclk,
   input logic                                arst_n,
   input logic                                out_valid,
   input logic                                out_ready,
   input l2d_ecc_pkg::req_kind_e              out_kind,
   input logic [l2d_ecc_pkg::code_w-1:0]      out_data,
   input logic                                err_corr,
   input logic                                err_uncorr,
   input logic                                scrub_corr,
   input logic                                scrub_uncorr,
   input logic [l2d_ecc_pkg::ret_err_w-1:0]   ret_err
);
   import l2d_ecc_pkg::*;

   // stalled output must not move
   hold_on_stall: assert property (@(posedge rclk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_kind))
      else $error("output changed while stalled");

   // empty c8 and reset both show quiet flags
   quiet_when_idle: assert property (@(posedge rclk)
      !arst_n || !out_valid |-> !err_corr && !err_uncorr && !scrub_corr &&
      !scrub_uncorr && ret_err == '0)
      else $error("flags set with no valid output");

   // precise code is only for processor loads
   ret_only_for_loads: assert property (@(posedge rclk) disable iff (!arst_n)
      out_valid && out_kind != kind_spc && out_kind != kind_fb |-> ret_err == '0)
      else $error("ret_err set for scrub or diagnostic");

endmodule

bind l2d_ecc_top l2d_ecc_assertions u_assertions (.*);

/* logic/l2d_ecc_top.sv */
////////////////////////////////////////
// data ecc check top level
// pipeline advance and stage instances
////////////////////////////////////////

module l2d_ecc_top (
   input  logic                                rclk,
   input  logic                                arst_n,
   input  logic                                ceen,
   input  logic                                nceen,
   input  logic                                in_valid,
   output logic                                in_ready,
   input  l2d_ecc_pkg::req_kind_e              in_kind,
   input  logic [1:0]                          in_word,
   input  logic [l2d_ecc_pkg::line_w-1:0]      in_line,
   input  logic                                in_dram_corr,
   input  logic                                in_dram_uncorr,
   output logic                                out_valid,
   input  logic                                out_ready,
   output l2d_ecc_pkg::req_kind_e              out_kind,
   output logic [l2d_ecc_pkg::code_w-1:0]      out_data,
   output logic                                err_corr,
   output logic                                err_uncorr,
   output logic                                scrub_corr,
   output logic                                scrub_uncorr,
   output logic [l2d_ecc_pkg::ret_err_w-1:0]   ret_err
);

   // c7 stage outputs
   logic                            advance;
   logic                            c7_valid;
   l2d_ecc_pkg::req_kind_e          c7_kind;
   logic [1:0]                      c7_word;
   logic [l2d_ecc_pkg::line_w-1:0]  c7_line;
   logic                            c7_dram_corr;
   logic                            c7_dram_uncorr;
   logic [l2d_ecc_pkg::syn_w-1:0]   c7_syn;
   logic [l2d_ecc_pkg::n_words-1:0] c7_perr;

   // c8 can take new data when empty or being drained
   assign advance  = ~out_valid | out_ready;
   // c7 frees up the same way, so full throughput with out_ready high
   assign in_ready = ~c7_valid | advance;

   l2d_ecc_check u_check (
      .rclk           (rclk),
      .arst_n         (arst_n),
      .load           (in_ready),
      .in_valid       (in_valid),
      .in_kind        (in_kind),
      .in_word        (in_word),
      .in_line        (in_line),
      .in_dram_corr   (in_dram_corr),
      .in_dram_uncorr (in_dram_uncorr),
      .advance        (advance),
      .c7_valid       (c7_valid),
      .c7_kind        (c7_kind),
      .c7_word        (c7_word),
      .c7_line        (c7_line),
      .c7_dram_corr   (c7_dram_corr),
      .c7_dram_uncorr (c7_dram_uncorr),
      .c7_syn         (c7_syn),
      .c7_perr        (c7_perr)
   );

   l2d_ecc_err_ctl u_err_ctl (
      .rclk           (rclk),
      .arst_n         (arst_n),
      .ceen           (ceen),
      .nceen          (nceen),
      .c7_valid       (c7_valid),
      .c7_kind        (c7_kind),
      .c7_word        (c7_word),
      .c7_dram_corr   (c7_dram_corr),
      .c7_dram_uncorr (c7_dram_uncorr),
      .c7_syn         (c7_syn),
      .c7_perr        (c7_perr),
      .advance        (advance),
      .err_corr       (err_corr),
      .err_uncorr     (err_uncorr),
      .scrub_corr     (scrub_corr),
      .scrub_uncorr   (scrub_uncorr),
      .ret_err        (ret_err)
   );

   l2d_read_select u_read_select (
      .rclk      (rclk),
      .arst_n    (arst_n),
      .advance   (advance),
      .c7_valid  (c7_valid),
      .c7_kind   (c7_kind),
      .c7_word   (c7_word),
      .c7_line   (c7_line),
      .c7_syn    (c7_syn),
      .c7_perr   (c7_perr),
      .out_valid (out_valid),
      .out_kind  (out_kind),
      .out_data  (out_data)
   );

endmodule

/* logic/l2d_read_select.sv */
////////////////////////////////////////
// addressed word select, single bit fix
// c8 data register
////////////////////////////////////////

module l2d_read_select (
   input  logic                            rclk,
   input  logic                            arst_n,
   input  logic                            advance,
   input  logic                            c7_valid,
   input  l2d_ecc_pkg::req_kind_e          c7_kind,
   input  logic [1:0]                      c7_word,
   input  logic [l2d_ecc_pkg::line_w-1:0]  c7_line,
   input  logic [l2d_ecc_pkg::syn_w-1:0]   c7_syn,
   input  logic [l2d_ecc_pkg::n_words-1:0] c7_perr,
   output logic                            out_valid,
   output l2d_ecc_pkg::req_kind_e          out_kind,
   output logic [l2d_ecc_pkg::code_w-1:0]  out_data
);
   import l2d_ecc_pkg::*;

   logic [2*code_w-1:0] half_sel;
   logic [code_w-1:0]   cw_sel;
   logic [chk_w-1:0]    syn_sel;
   logic                do_fix;
   logic [code_w-1:0]   fixed;
   logic [word_w-1:0]   data_ext;

   // 4:1 as two 2:1 stages, address bit 3 then bit 2
   assign half_sel = c7_word[1] ? c7_line[line_w-1 -: 2*code_w] : c7_line[2*code_w-1:0];
   assign cw_sel   = c7_word[0] ? half_sel[2*code_w-1 -: code_w] : half_sel[code_w-1:0];
   assign syn_sel  = c7_syn[c7_word*chk_w +: chk_w];

   // syndrome names the failing hamming position, only 1..38 exist
   assign do_fix = (c7_kind != kind_diag) & c7_perr[c7_word] &
                   (syn_sel != '0) & (syn_sel < chk_w'(code_w));

   always_comb begin
      fixed = cw_sel;
      if (do_fix) begin
         fixed[syn_sel-1] = ~fixed[syn_sel-1];
      end
   end

   // data bits sit at the non power of two positions, low to high
   always_comb begin
      int k;
      k = 0;
      data_ext = '0;
      for (int p = 1; p < code_w; p++) begin
         if ((p & (p - 1)) != 0) begin
            data_ext[k] = fixed[p-1];
            k++;
         end
      end
   end

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (advance) begin
         out_valid <= c7_valid;
      end
   end

   // diagnostic reads get the raw codeword back
   always_ff @(posedge rclk) begin
      if (advance && c7_valid) begin
         out_kind <= c7_kind;
         out_data <= (c7_kind == kind_diag) ? cw_sel : {{(code_w-word_w){1'b0}}, data_ext};
      end
   end

endmodule

/* logic/l2d_ecc_err_ctl.sv */
////////////////////////////////////////
// error classification per request source
// scrub half select
// enable gated return error code, c8 flags
////////////////////////////////////////

module l2d_ecc_err_ctl (
   input  logic                                rclk,
   input  logic                                arst_n,
   input  logic                                ceen,
   input  logic                                nceen,
   input  logic                                c7_valid,
   input  l2d_ecc_pkg::req_kind_e              c7_kind,
   input  logic [1:0]                          c7_word,
   input  logic                                c7_dram_corr,
   input  logic                                c7_dram_uncorr,
   input  logic [l2d_ecc_pkg::syn_w-1:0]       c7_syn,
   input  logic [l2d_ecc_pkg::n_words-1:0]     c7_perr,
   input  logic                                advance,
   output logic                                err_corr,
   output logic                                err_uncorr,
   output logic                                scrub_corr,
   output logic                                scrub_uncorr,
   output logic [l2d_ecc_pkg::ret_err_w-1:0]   ret_err
);
   import l2d_ecc_pkg::*;

   // registered enables
   logic                 ceen_q;
   logic                 nceen_q;
   // per-word class
   logic [n_words-1:0]   word_corr;
   logic [n_words-1:0]   word_uncorr;
   // whole line and selected half
   logic                 line_corr;
   logic                 line_uncorr;
   logic                 half_corr;
   logic                 half_uncorr;
   // next c8 values
   logic                 corr_nxt;
   logic                 uncorr_nxt;
   logic                 scr_corr_nxt;
   logic                 scr_uncorr_nxt;
   logic [ret_err_w-1:0] ret_nxt;

   ////////////////////////////////////////
   // classification
   ////////////////////////////////////////

   // parity error means an odd number of flips, taken as a single bit;
   // nonzero syndrome with good parity is a double bit error
   always_comb begin
      for (int w = 0; w < n_words; w++) begin
         word_corr[w]   = c7_perr[w];
         word_uncorr[w] = (|c7_syn[w*chk_w +: chk_w]) & ~c7_perr[w];
      end
   end

   assign line_corr   = |word_corr;
   assign line_uncorr = |word_uncorr;

   // scrub looks at one 64-bit half, words 2 and 3 when address bit 3 is set
   assign half_corr   = c7_word[1] ? (word_corr[3] | word_corr[2])
                                   : (word_corr[1] | word_corr[0]);
   assign half_uncorr = c7_word[1] ? (word_uncorr[3] | word_uncorr[2])
                                   : (word_uncorr[1] | word_uncorr[0]);

   // attribute to the request source
   always_comb begin
      corr_nxt       = 1'b0;
      uncorr_nxt     = 1'b0;
      scr_corr_nxt   = 1'b0;
      scr_uncorr_nxt = 1'b0;
      ret_nxt        = '0;
      case (c7_kind)
         kind_spc, kind_diag: begin
            corr_nxt   = line_corr;
            uncorr_nxt = line_uncorr;
         end
         kind_fb: begin
            // dram errors come along with the fill
            corr_nxt   = line_corr | c7_dram_corr;
            uncorr_nxt = line_uncorr | c7_dram_uncorr;
         end
         kind_scrub: begin
            scr_corr_nxt   = half_corr;
            scr_uncorr_nxt = half_uncorr;
         end
         default: begin
         end
      endcase
      // precise report only goes to processor loads
      if (c7_kind == kind_spc || c7_kind == kind_fb) begin
         ret_nxt[ret_corr]   = corr_nxt & ceen_q;
         ret_nxt[ret_uncorr] = uncorr_nxt & nceen_q;
      end
   end

   ////////////////////////////////////////
   // registers
   ////////////////////////////////////////

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         ceen_q  <= 1'b0;
         nceen_q <= 1'b0;
      end else begin
         ceen_q  <= ceen;
         nceen_q <= nceen;
      end
   end

   // flags are qualified by c7_valid so an empty c8 shows all zero
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         err_corr     <= 1'b0;
         err_uncorr   <= 1'b0;
         scrub_corr   <= 1'b0;
         scrub_uncorr <= 1'b0;
         ret_err      <= '0;
      end else if (advance) begin
         err_corr     <= c7_valid & corr_nxt;
         err_uncorr   <= c7_valid & uncorr_nxt;
         scrub_corr   <= c7_valid & scr_corr_nxt;
         scrub_uncorr <= c7_valid & scr_uncorr_nxt;
         ret_err      <= c7_valid ? ret_nxt : '0;
      end
   end

endmodule

/* logic/l2d_ecc_check.sv */
////////////////////////////////////////
// c7 stage of the data ecc check
// per-codeword syndrome and parity error
////////////////////////////////////////

module l2d_ecc_check (
   input  logic                            rclk,
   input  logic                            arst_n,
   input  logic                            load,
   input  logic                            in_valid,
   input  l2d_ecc_pkg::req_kind_e          in_kind,
   input  logic [1:0]                      in_word,
   input  logic [l2d_ecc_pkg::line_w-1:0]  in_line,
   input  logic                            in_dram_corr,
   input  logic                            in_dram_uncorr,
   input  logic                            advance,
   output logic                            c7_valid,
   output l2d_ecc_pkg::req_kind_e          c7_kind,
   output logic [1:0]                      c7_word,
   output logic [l2d_ecc_pkg::line_w-1:0]  c7_line,
   output logic                            c7_dram_corr,
   output logic                            c7_dram_uncorr,
   output logic [l2d_ecc_pkg::syn_w-1:0]   c7_syn,
   output logic [l2d_ecc_pkg::n_words-1:0] c7_perr
);
   import l2d_ecc_pkg::*;

   // request accepted this cycle
   logic               take;
   logic [syn_w-1:0]   syn_nxt;
   logic [n_words-1:0] perr_nxt;

   // load says the stage has room, in_valid says there is something to take
   assign take = load & in_valid;

   ////////////////////////////////////////
   // syndrome generation
   ////////////////////////////////////////

   // bit b of the syndrome is the xor of every hamming position whose index
   // has bit b set, the stored check bit included, so this already equals
   // stored xor recomputed check bits
   always_comb begin
      logic [code_w-1:0] cw;
      logic [chk_w-1:0]  s;
      for (int w = 0; w < n_words; w++) begin
         cw = in_line[w*code_w +: code_w];
         s = '0;
         for (int p = 1; p < code_w; p++) begin
            for (int b = 0; b < chk_w; b++) begin
               if (p[b]) begin
                  s[b] = s[b] ^ cw[p-1];
               end
            end
         end
         syn_nxt[w*chk_w +: chk_w] = s;
         // bit 38 keeps even parity over the whole codeword
         perr_nxt[w] = ^cw;
      end
   end

   ////////////////////////////////////////
   // c7 register
   ////////////////////////////////////////

   // new entry wins over a drain in the same cycle
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         c7_valid <= 1'b0;
      end else if (take) begin
         c7_valid <= 1'b1;
      end else if (advance) begin
         c7_valid <= 1'b0;
      end
   end

   // payload only moves with a new request
   always_ff @(posedge rclk) begin
      if (take) begin
         c7_kind        <= in_kind;
         c7_word        <= in_word;
         c7_line        <= in_line;
         c7_dram_corr   <= in_dram_corr;
         c7_dram_uncorr <= in_dram_uncorr;
         c7_syn         <= syn_nxt;
         c7_perr        <= perr_nxt;
      end
   end

endmodule

/* logic/l2d_ecc_pkg.sv */
////////////////////////////////////////
// shared widths for the l2 data ecc path
// request source encoding
// return error code bit layout
////////////////////////////////////////

package l2d_ecc_pkg;

   // data bits carried by one codeword
   localparam int word_w = 32;
   // hamming check bits per codeword
   localparam int chk_w = 6;
   // 32 data + 6 check + 1 overall parity
   localparam int code_w = 39;
   // codewords held in one array line
   localparam int n_words = 4;
   // full line as read from the data array
   localparam int line_w = n_words * code_w;
   // all per-word syndromes packed side by side
   localparam int syn_w = n_words * chk_w;

   // request source, decides how errors get reported
   typedef enum logic [1:0] {
      // processor load
      kind_spc   = 2'd0,
      // fill buffer return to the processor
      kind_fb    = 2'd1,
      // background scrub, only one 64-bit half counts
      kind_scrub = 2'd2,
      // diagnostic access, raw codeword goes back
      kind_diag  = 2'd3
   } req_kind_e;

   // precise error code back to the processor
   localparam int ret_err_w = 2;
   localparam int ret_corr = 0;
   localparam int ret_uncorr = 1;

endpackage
